//--- hw/rs_defines.svh
`ifndef RS_DEFINES_SVH
`define RS_DEFINES_SVH

// number of common data bus lanes
`define RS_WAYS 2

// operand and result width
`define RS_XLEN 32

// physical register file entries
`define RS_PRF 64

// reservation station slots
`define RS_SIZE 8

// opcode field width
`define RS_OPW 8

`endif

//--- hw/rs_entry.sv
`default_nettype none
`timescale 1ns/1ps

`include "rs_defines.svh"

module rs_entry
    import rs_pkg::*;
(
    input  wire logic                      clock,
    input  wire logic                      arst_n,

    input  wire cdb_lane_t [`RS_WAYS-1:0]  cdb,

    input  wire logic                      load,
    input  wire dispatch_t                 dispatch_in,
    input  wire logic                      clear,

    output dispatch_t                      slot_out,
    output logic                           ready,
    output logic                           is_free
);

    logic                occupied;
    logic [`RS_OPW-1:0]  opcode_q;
    prf_idx_t            dest_q;
    operand_t            op_a_q;
    operand_t            op_b_q;

    operand_t            op_a_src;
    operand_t            op_b_src;
    operand_t            op_a_next;
    operand_t            op_b_next;

    // replace a waiting tag with lane data, later lanes override earlier ones
    function automatic operand_t wake(
        input operand_t                   op,
        input cdb_lane_t [`RS_WAYS-1:0]   lanes
    );
        operand_t result;
        result = op;
        for (int i = 0; i < `RS_WAYS; i++) begin
            if (!op.ready && lanes[i].valid && lanes[i].tag == prf_idx_t'(op.value)) begin
                result.value = lanes[i].data;
                result.ready = 1'b1;
            end
        end
        return result;
    endfunction

    // on a load the incoming operands see the bus in the same cycle
    always_comb begin
        if (load) begin
            op_a_src = dispatch_in.a;
            op_b_src = dispatch_in.b;
        end else begin
            op_a_src = op_a_q;
            op_b_src = op_b_q;
        end
        op_a_next = wake(op_a_src, cdb);
        op_b_next = wake(op_b_src, cdb);
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            occupied <= 1'b0;
        end else if (load) begin
            occupied <= dispatch_in.valid;
        end else if (clear) begin
            occupied <= 1'b0;
        end
    end

    // packet fields and operand wakeup
    always_ff @(posedge clock) begin
        if (load) begin
            opcode_q <= dispatch_in.opcode;
            dest_q   <= dispatch_in.dest;
        end
        if (load || occupied) begin
            op_a_q <= op_a_next;
            op_b_q <= op_b_next;
        end
    end

    always_comb begin
        slot_out.valid  = occupied;
        slot_out.opcode = opcode_q;
        slot_out.dest   = dest_q;
        slot_out.a      = op_a_q;
        slot_out.b      = op_b_q;
    end

    assign ready   = occupied && op_a_q.ready && op_b_q.ready;
    assign is_free = !occupied;

    // allocation and issue pick disjoint slots
    a_no_load_and_clear: assert property (
        @(posedge clock) disable iff (!arst_n)
        !(load && clear)
    );

    // allocator only targets free slots
    a_load_when_free: assert property (
        @(posedge clock) disable iff (!arst_n)
        load |-> !occupied
    );

endmodule

`default_nettype wire

//--- hw/rs_occupancy_counter.sv
`default_nettype none
`timescale 1ns/1ps

`include "rs_defines.svh"

module rs_occupancy_counter
    import rs_pkg::*;
(
    input  wire logic clock,
    input  wire logic arst_n,

    input  wire logic increment,
    input  wire logic decrement,

    output count_t    count,
    output logic      full
);

    count_t count_next;

    // simultaneous increment and decrement cancel
    always_comb begin
        count_next = count;
        case ({increment, decrement})
            2'b10:   count_next = count + count_t'(1);
            2'b01:   count_next = count - count_t'(1);
            default: count_next = count;
        endcase
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
            full  <= 1'b0;
        end else begin
            count <= count_next;
            full  <= (count_next == count_t'(`RS_SIZE));
        end
    end

    // dispatch must be gated by full
    a_no_inc_when_full: assert property (
        @(posedge clock) disable iff (!arst_n)
        increment |-> !full
    );

    a_no_dec_at_zero: assert property (
        @(posedge clock) disable iff (!arst_n)
        decrement |-> (count != '0)
    );

endmodule

`default_nettype wire

//--- hw/rs_pick_first.sv
`default_nettype none
`timescale 1ns/1ps

module rs_pick_first #(
    parameter int WIDTH = 8
) (
    input  wire logic [WIDTH-1:0] request,
    output logic      [WIDTH-1:0] grant,
    output logic                  any
);

    logic [WIDTH-1:0] request_neg;

    // two's complement isolates the lowest set bit
    always_comb begin
        request_neg = ~request + WIDTH'(1);
        grant       = request & request_neg;
        // one bit at most, only where asked, and no request below it
        a_grant_lowest_onehot: assert ($onehot0(grant) && ((grant & ~request) == '0)
                                       && ((request & (grant - WIDTH'(1))) == '0))
        else $error("rs_pick_first grant %b not valid for request %b", grant, request);
    end

    assign any = |request;

endmodule

`default_nettype wire

//--- hw/rs_pkg.sv
`default_nettype none

`include "rs_defines.svh"

package rs_pkg;

    localparam int TAG_W = $clog2(`RS_PRF);

    // physical register tag
    typedef logic [TAG_W-1:0] prf_idx_t;

    // value when ready is set, tag in the low bits otherwise
    typedef struct packed {
        logic               ready;
        logic [`RS_XLEN-1:0] value;
    } operand_t;

    // one broadcast lane of the cdb
    typedef struct packed {
        logic                valid;
        prf_idx_t            tag;
        logic [`RS_XLEN-1:0] data;
    } cdb_lane_t;

    typedef struct packed {
        logic             valid;
        logic [`RS_OPW-1:0] opcode;
        prf_idx_t         dest;
        operand_t         a;
        operand_t         b;
    } dispatch_t;

    // issued packet, both operands resolved
    typedef struct packed {
        logic                valid;
        logic [`RS_OPW-1:0]  opcode;
        prf_idx_t            dest;
        logic [`RS_XLEN-1:0] a;
        logic [`RS_XLEN-1:0] b;
    } issue_t;

    typedef logic [$clog2(`RS_SIZE+1)-1:0] count_t;

endpackage

`default_nettype wire

//--- hw/rs_top.sv
`default_nettype none
`timescale 1ns/1ps

`include "rs_defines.svh"

module rs_top
    import rs_pkg::*;
(
    input  wire logic                      clock,
    input  wire logic                      arst_n,

    input  wire dispatch_t                 dispatch,
    input  wire cdb_lane_t [`RS_WAYS-1:0]  cdb,
    input  wire logic                      issue_stall,

    output issue_t                         issue,
    output logic                           dispatch_ready,
    output count_t                         count
);

    dispatch_t              slots [`RS_SIZE];
    logic [`RS_SIZE-1:0]    free_vec;
    logic [`RS_SIZE-1:0]    ready_vec;

    logic [`RS_SIZE-1:0]    alloc_grant;
    logic                   alloc_any;
    logic [`RS_SIZE-1:0]    issue_request;
    logic [`RS_SIZE-1:0]    issue_grant;
    logic                   issue_any;

    logic [`RS_SIZE-1:0]    load_vec;
    logic [`RS_SIZE-1:0]    clear_vec;
    logic                   accept;
    logic                   full;
    dispatch_t              picked;

    assign dispatch_ready = !full;
    assign accept         = dispatch.valid && !full;

    // dispatch goes to the lowest free slot
    rs_pick_first #(
        .WIDTH (`RS_SIZE)
    ) u_alloc_pick (
        .request (free_vec),
        .grant   (alloc_grant),
        .any     (alloc_any)
    );

    // stall masks every request so all slots hold
    assign issue_request = ready_vec & {`RS_SIZE{!issue_stall}};

    rs_pick_first #(
        .WIDTH (`RS_SIZE)
    ) u_issue_pick (
        .request (issue_request),
        .grant   (issue_grant),
        .any     (issue_any)
    );

    assign load_vec  = alloc_grant & {`RS_SIZE{accept}};
    assign clear_vec = issue_grant;

    for (genvar i = 0; i < `RS_SIZE; i++) begin : g_slot
        rs_entry u_entry (
            .clock       (clock),
            .arst_n      (arst_n),
            .cdb         (cdb),
            .load        (load_vec[i]),
            .dispatch_in (dispatch),
            .clear       (clear_vec[i]),
            .slot_out    (slots[i]),
            .ready       (ready_vec[i]),
            .is_free     (free_vec[i])
        );
    end

    // one-hot mux of the granted slot
    always_comb begin
        picked = '0;
        for (int i = 0; i < `RS_SIZE; i++) begin
            if (issue_grant[i]) begin
                picked = slots[i];
            end
        end
    end

    always_comb begin
        issue.valid  = issue_any;
        issue.opcode = picked.opcode;
        issue.dest   = picked.dest;
        issue.a      = picked.a.value;
        issue.b      = picked.b.value;
    end

    rs_occupancy_counter u_occupancy (
        .clock     (clock),
        .arst_n    (arst_n),
        .increment (accept),
        .decrement (issue_any),
        .count     (count),
        .full      (full)
    );

    // registered count tracks the slot flags
    a_count_matches_slots: assert property (
        @(posedge clock) disable iff (!arst_n)
        count == count_t'($countones(~free_vec))
    );

    // full only when the allocator finds nothing
    a_full_matches_alloc: assert property (
        @(posedge clock) disable iff (!arst_n)
        full == !alloc_any
    );

endmodule

`default_nettype wire

//--- rs_top.f
+incdir+hw
hw/rs_pkg.sv
hw/rs_pick_first.sv
hw/rs_occupancy_counter.sv
hw/rs_entry.sv
hw/rs_top.sv
verification/rs_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the reservation station testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module rs_tb -f rs_top.f \
    && ./obj_dir/Vrs_tb | tee /dev/stderr | grep -F -x '** PASS **' > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- verification/rs_tb.sv
`default_nettype none
`timescale 1ns/1ps

`include "rs_defines.svh"

module rs_tb
    import rs_pkg::*;
();

    localparam int CLK_PERIOD    = 100;
    localparam int RANDOM_CYCLES = 1200;
    // directed tests and drains stay well under 800 cycles
    localparam int CYCLE_LIMIT   = RANDOM_CYCLES + 800;
    localparam int DRAIN_LIMIT   = 64;

    logic                      clock;
    logic                      arst_n;
    dispatch_t                 dispatch;
    cdb_lane_t [`RS_WAYS-1:0]  cdb;
    logic                      issue_stall;
    issue_t                    issue;
    logic                      dispatch_ready;
    count_t                    count;

    logic [31:0]               lcg_state = 32'hd789;
    int                        cycle_count = 0;
    string                     test_name = "reset";

    // reference model of the slots
    logic                      m_busy  [`RS_SIZE];
    logic [`RS_OPW-1:0]        m_opcode[`RS_SIZE];
    prf_idx_t                  m_dest  [`RS_SIZE];
    logic                      m_a_rdy [`RS_SIZE];
    logic [`RS_XLEN-1:0]       m_a_val [`RS_SIZE];
    logic                      m_b_rdy [`RS_SIZE];
    logic [`RS_XLEN-1:0]       m_b_val [`RS_SIZE];
    int                        m_count;
    issue_t                    exp_issue;

    rs_top u_rs_top (
        .clock          (clock),
        .arst_n         (arst_n),
        .dispatch       (dispatch),
        .cdb            (cdb),
        .issue_stall    (issue_stall),
        .issue          (issue),
        .dispatch_ready (dispatch_ready),
        .count          (count)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic operand_t value_op(input logic [`RS_XLEN-1:0] v);
        return '{ready: 1'b1, value: v};
    endfunction

    function automatic operand_t tag_op(input prf_idx_t t);
        return '{ready: 1'b0, value: `RS_XLEN'(t)};
    endfunction

    // half resolved values, half waiting on tags 0 to 15
    function automatic operand_t random_operand();
        logic [31:0] r;
        r = next_random();
        if (r[31]) begin
            return value_op(next_random());
        end
        return tag_op(prf_idx_t'(r[30:27]));
    endfunction

    function automatic int lowest_ready();
        int pick;
        pick = -1;
        for (int i = `RS_SIZE - 1; i >= 0; i--) begin
            if (m_busy[i] && m_a_rdy[i] && m_b_rdy[i]) begin
                pick = i;
            end
        end
        return pick;
    endfunction

    function automatic int lowest_free();
        int pick;
        pick = -1;
        for (int i = `RS_SIZE - 1; i >= 0; i--) begin
            if (!m_busy[i]) begin
                pick = i;
            end
        end
        return pick;
    endfunction

    // highest matching lane supplies the value
    function automatic logic [`RS_XLEN:0] snoop(input logic rdy, input logic [`RS_XLEN-1:0] val);
        if (rdy) begin
            return {rdy, val};
        end
        for (int l = `RS_WAYS - 1; l >= 0; l--) begin
            if (cdb[l].valid && cdb[l].tag == val[TAG_W-1:0]) begin
                return {1'b1, cdb[l].data};
            end
        end
        return {rdy, val};
    endfunction

    always @(posedge clock or negedge arst_n) begin
        int iss;
        int slot;
        logic accept;
        logic [`RS_XLEN:0] res;
        if (!arst_n) begin
            for (int i = 0; i < `RS_SIZE; i++) begin
                m_busy[i]  = 1'b0;
                m_a_rdy[i] = 1'b0;
                m_b_rdy[i] = 1'b0;
            end
            m_count = 0;
        end else begin
            iss    = issue_stall ? -1 : lowest_ready();
            slot   = lowest_free();
            accept = dispatch.valid && (m_count < `RS_SIZE);
            for (int i = 0; i < `RS_SIZE; i++) begin
                if (m_busy[i]) begin
                    res        = snoop(m_a_rdy[i], m_a_val[i]);
                    m_a_rdy[i] = res[`RS_XLEN];
                    m_a_val[i] = res[`RS_XLEN-1:0];
                    res        = snoop(m_b_rdy[i], m_b_val[i]);
                    m_b_rdy[i] = res[`RS_XLEN];
                    m_b_val[i] = res[`RS_XLEN-1:0];
                end
            end
            if (iss >= 0) begin
                m_busy[iss] = 1'b0;
                m_count--;
            end
            // new packet sees the bus in its own load cycle
            if (accept) begin
                m_busy[slot]   = 1'b1;
                m_opcode[slot] = dispatch.opcode;
                m_dest[slot]   = dispatch.dest;
                res            = snoop(dispatch.a.ready, dispatch.a.value);
                m_a_rdy[slot]  = res[`RS_XLEN];
                m_a_val[slot]  = res[`RS_XLEN-1:0];
                res            = snoop(dispatch.b.ready, dispatch.b.value);
                m_b_rdy[slot]  = res[`RS_XLEN];
                m_b_val[slot]  = res[`RS_XLEN-1:0];
                m_count++;
            end
        end
    end

    always_comb begin
        int pick;
        exp_issue = '0;
        pick = issue_stall ? -1 : lowest_ready();
        if (pick >= 0) begin
            exp_issue.valid  = 1'b1;
            exp_issue.opcode = m_opcode[pick];
            exp_issue.dest   = m_dest[pick];
            exp_issue.a      = m_a_val[pick];
            exp_issue.b      = m_b_val[pick];
        end
    end

    task automatic report_mismatch(input string what, input logic [63:0] expected,
                                   input logic [63:0] actual);
        $display("ERROR %s: %s expected %0h actual %0h", test_name, what, expected, actual);
        $display("** FAIL **");
        $fatal(1, "DUT disagrees with reference model");
    endtask

    // outputs are compared mid-cycle, away from both edges
    a_issue_valid: assert property (@(negedge clock) disable iff (!arst_n)
        issue.valid == exp_issue.valid)
        else report_mismatch("issue valid", 64'(exp_issue.valid), 64'(issue.valid));

    a_issue_opcode: assert property (@(negedge clock) disable iff (!arst_n)
        exp_issue.valid |-> issue.opcode == exp_issue.opcode)
        else report_mismatch("issue opcode", 64'(exp_issue.opcode), 64'(issue.opcode));

    a_issue_dest: assert property (@(negedge clock) disable iff (!arst_n)
        exp_issue.valid |-> issue.dest == exp_issue.dest)
        else report_mismatch("issue dest", 64'(exp_issue.dest), 64'(issue.dest));

    a_issue_a: assert property (@(negedge clock) disable iff (!arst_n)
        exp_issue.valid |-> issue.a == exp_issue.a)
        else report_mismatch("issue a", 64'(exp_issue.a), 64'(issue.a));

    a_issue_b: assert property (@(negedge clock) disable iff (!arst_n)
        exp_issue.valid |-> issue.b == exp_issue.b)
        else report_mismatch("issue b", 64'(exp_issue.b), 64'(issue.b));

    a_count: assert property (@(negedge clock) disable iff (!arst_n)
        count == count_t'(m_count))
        else report_mismatch("count", 64'(m_count), 64'(count));

    a_dispatch_ready: assert property (@(negedge clock) disable iff (!arst_n)
        dispatch_ready == (m_count != `RS_SIZE))
        else report_mismatch("dispatch_ready", 64'(m_count != `RS_SIZE), 64'(dispatch_ready));

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: run passed %0d cycles during %s", CYCLE_LIMIT, test_name);
            $display("** FAIL **");
            $fatal(1, "cycle limit reached");
        end
    end

    task automatic tick();
        @(posedge clock);
        #1;
    endtask

    task automatic put_dispatch(input logic [`RS_OPW-1:0] opcode, input prf_idx_t dest,
                                input operand_t a, input operand_t b);
        dispatch.valid  = 1'b1;
        dispatch.opcode = opcode;
        dispatch.dest   = dest;
        dispatch.a      = a;
        dispatch.b      = b;
    endtask

    task automatic put_lane(input int lane, input prf_idx_t tag, input logic [`RS_XLEN-1:0] data);
        cdb[lane].valid = 1'b1;
        cdb[lane].tag   = tag;
        cdb[lane].data  = data;
    endtask

    task automatic idle(input int cycles);
        dispatch.valid = 1'b0;
        cdb            = '0;
        repeat (cycles) tick();
    endtask

    task automatic wait_until_empty();
        int waited;
        waited = 0;
        dispatch.valid = 1'b0;
        cdb            = '0;
        while (count != '0) begin
            if (waited == DRAIN_LIMIT) begin
                $display("station still holds %0d entries after %0d cycles in %s",
                         count, DRAIN_LIMIT, test_name);
                $display("** FAIL **");
                $fatal(1, "drain timeout");
            end else begin
                tick();
                waited++;
            end
        end
    endtask

    initial begin
        logic [31:0] r;
        arst_n      = 1'b0;
        dispatch    = '0;
        cdb         = '0;
        issue_stall = 1'b0;
        repeat (4) @(posedge clock);
        #1;
        arst_n = 1'b1;
        idle(2);

        test_name = "ready dispatch";
        for (int k = 0; k < 3; k++) begin
            r = next_random();
            put_dispatch(r[31:24], prf_idx_t'(r[23:18]), value_op(next_random()),
                         value_op(next_random()));
            tick();
        end
        wait_until_empty();

        test_name = "cdb wakeup";
        put_dispatch(8'h11, 6'd40, tag_op(6'd5), value_op(32'h0000_1234));
        tick();
        idle(2);
        put_lane(0, 6'd5, 32'hcafe_0005);
        tick();
        wait_until_empty();
        // broadcast in the dispatch cycle
        put_dispatch(8'h22, 6'd41, tag_op(6'd7), tag_op(6'd8));
        put_lane(1, 6'd7, 32'hbeef_0007);
        put_lane(0, 6'd8, 32'hbeef_0008);
        tick();
        wait_until_empty();
        // both lanes carry the same tag
        put_dispatch(8'h33, 6'd42, tag_op(6'd9), value_op(32'h0000_0099));
        tick();
        idle(1);
        put_lane(0, 6'd9, 32'h0000_aaaa);
        put_lane(1, 6'd9, 32'h0000_bbbb);
        tick();
        wait_until_empty();

        test_name = "full";
        for (int k = 0; k < `RS_SIZE; k++) begin
            put_dispatch(`RS_OPW'(8'h40 + k), prf_idx_t'(k), tag_op(prf_idx_t'(16 + k)),
                         value_op(32'(k)));
            tick();
        end
        put_dispatch(8'hee, 6'd63, value_op(32'h1), value_op(32'h2));
        repeat (2) tick();
        idle(0);
        for (int k = 0; k < `RS_SIZE; k += 2) begin
            put_lane(0, prf_idx_t'(16 + k), next_random());
            put_lane(1, prf_idx_t'(17 + k), next_random());
            tick();
        end
        wait_until_empty();

        test_name = "issue order and stall";
        issue_stall = 1'b1;
        for (int k = 0; k < 4; k++) begin
            put_dispatch(`RS_OPW'(8'h60 + k), prf_idx_t'(k + 8), value_op(next_random()),
                         value_op(next_random()));
            tick();
        end
        put_dispatch(8'h6f, 6'd30, tag_op(6'd30), value_op(32'h3));
        tick();
        idle(0);
        // wakeup still lands while stalled
        put_lane(1, 6'd30, 32'h0303_0303);
        tick();
        idle(3);
        issue_stall = 1'b0;
        wait_until_empty();

        test_name = "random mix";
        repeat (RANDOM_CYCLES) begin
            r        = next_random();
            dispatch = '0;
            cdb      = '0;
            if (r[31]) begin
                put_dispatch(r[23:16], prf_idx_t'(r[15:10]), random_operand(),
                             random_operand());
            end
            issue_stall = (r[30:29] == 2'b00);
            for (int l = 0; l < `RS_WAYS; l++) begin
                r = next_random();
                if (r[31]) begin
                    put_lane(l, prf_idx_t'(r[30:27]), next_random());
                end
            end
            tick();
        end
        issue_stall = 1'b0;
        idle(0);
        // every waiting tag lies in 0 to 15
        for (int t = 0; t < 16; t++) begin
            cdb = '0;
            put_lane(0, prf_idx_t'(t), next_random());
            tick();
        end
        wait_until_empty();

        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire
